// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = packet_capture_tb
RTL_TOP    = packet_capture
FILELIST   = list.f
OBJ_DIR    = obj_dir
PASS_MSG   = All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/packet_capture_tb.sv
`timescale 1ns/1ps

module packet_capture_tb;

    import capture_pkg::*;

    typedef logic [7:0] byte_q_t [$];

    // Packets sent over the whole run, sets the watchdog limit
    localparam int packet_count = 24;
    localparam int timeout_ns   = packet_count * 200_000 + 1_000_000;

    logic         clk;
    logic         arst_n;
    axil_req_t    axil_req;
    axil_rsp_t    axil_rsp;
    packet_beat_t pkt;
    logic         pkt_valid;
    logic         pkt_ready;
    int           error_count = 0;
    int           check_count = 0;
    int           test_pass = 0;
    int           test_fail = 0;

    tb_clock u_tb_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    packet_capture dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .pkt       (pkt),
        .pkt_valid (pkt_valid),
        .pkt_ready (pkt_ready)
    );

    // ==============================
    // Reference and compare
    // ==============================
    // Big-endian word at byte offset a, zero past the end
    function automatic reg_data_t expected_word(input byte_q_t bytes, input int a);
        reg_data_t word;
        word = '0;
        for (int k = 0; k < 4; k++)
        begin
            if (a + k < bytes.size())
            begin
                word[(3 - k) * 8 +: 8] = bytes[a + k];
            end
        end
        return word;
    endfunction

    task automatic compare_reg(input string name, input reg_data_t got, input reg_data_t exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic compare_ready(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic compare_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before)
        begin
            test_pass++;
            $display("test %s: ok", name);
        end
        else
        begin
            test_fail++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // ==============================
    // AXI4-Lite master
    // ==============================
    task automatic axil_write(input reg_addr_t addr, input reg_data_t data);
        @(posedge clk);
        axil_req.awaddr  <= addr;
        axil_req.awvalid <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= 4'hf;
        axil_req.wvalid  <= 1'b1;
        axil_req.bready  <= 1'b1;
        @(negedge clk);
        while (!(axil_rsp.awready && axil_rsp.wready))
        begin
            @(negedge clk);
        end
        @(posedge clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        @(negedge clk);
        while (!axil_rsp.bvalid)
        begin
            @(negedge clk);
        end
        // OKAY is the only response
        compare_resp("bresp", axil_rsp.bresp, 2'b00);
        @(posedge clk);
        axil_req.bready <= 1'b0;
    endtask

    task automatic axil_read(input reg_addr_t addr, output reg_data_t data);
        @(posedge clk);
        axil_req.araddr  <= addr;
        axil_req.arvalid <= 1'b1;
        axil_req.rready  <= 1'b1;
        @(negedge clk);
        while (!axil_rsp.arready)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
        @(negedge clk);
        while (!axil_rsp.rvalid)
        begin
            @(negedge clk);
        end
        data = axil_rsp.rdata;
        compare_resp("rresp", axil_rsp.rresp, 2'b00);
        @(posedge clk);
        axil_req.rready <= 1'b0;
    endtask

    // ==============================
    // Packet side
    // ==============================
    task automatic make_packet(input int len, output byte_q_t bytes);
        bytes = {};
        for (int i = 0; i < len; i++)
        begin
            bytes.push_back(8'($urandom()));
        end
    endtask

    task automatic send_packet(input byte_q_t bytes, input meta_t meta, input bit check_ready);
        int           len;
        int           n_beats;
        packet_beat_t beat;
        len     = bytes.size();
        n_beats = (len + data_bytes - 1) / data_bytes;
        @(posedge clk);
        for (int b = 0; b < n_beats; b++)
        begin
            beat = '0;
            for (int k = 0; k < data_bytes; k++)
            begin
                if (b * data_bytes + k < len)
                begin
                    beat.data[(data_bytes - 1 - k) * 8 +: 8] = bytes[b * data_bytes + k];
                end
            end
            beat.eop = (b == n_beats - 1);
            if (beat.eop)
            begin
                beat.mty  = mty_t'(n_beats * data_bytes - len);
                beat.meta = meta;
            end
            pkt       <= beat;
            pkt_valid <= 1'b1;
            @(negedge clk);
            if (check_ready)
            begin
                compare_ready("pkt_ready", pkt_ready, 1'b1);
            end
            while (!pkt_ready)
            begin
                @(negedge clk);
            end
            @(posedge clk);
        end
        pkt_valid <= 1'b0;
    endtask

    // Waits for done, then checks length, metadata and every window word
    task automatic check_capture(input byte_q_t bytes, input meta_t meta);
        reg_data_t value;
        int        polls;
        value = '0;
        polls = 0;
        while (value[0] !== 1'b1 && polls < 1000)
        begin
            axil_read(reg_status, value);
            polls++;
        end
        if (value[0] !== 1'b1)
        begin
            error_count++;
            $display("capture never reported done after %0d status polls", polls);
        end
        compare_reg("status", value, 32'h1);
        axil_read(reg_pkt_len, value);
        compare_reg("pkt_len", value, reg_data_t'(bytes.size()));
        axil_read(reg_pkt_meta, value);
        compare_reg("pkt_meta", value, reg_data_t'(meta));
        for (int a = 0; a < bytes.size(); a += 4)
        begin
            axil_read(mem_window_base + reg_addr_t'(a), value);
            compare_reg($sformatf("window[0x%03h]", a), value, expected_word(bytes, a));
        end
    endtask

    // ==============================
    // Tests
    // ==============================
    initial
    begin
        byte_q_t   bytes;
        meta_t     meta;
        reg_data_t value;
        int        errors_before;
        int        first_len;
        axil_req  <= '0;
        pkt       <= '0;
        pkt_valid <= 1'b0;
        void'($urandom(32'h2330_2fd8));
        wait (arst_n === 1'b1);
        @(posedge clk);

        errors_before = error_count;
        axil_read(reg_status, value);
        compare_reg("status", value, 32'h0);
        axil_read(reg_pkt_len, value);
        compare_reg("pkt_len", value, 32'h0);
        axil_read(reg_pkt_meta, value);
        compare_reg("pkt_meta", value, 32'h0);
        finish_test("reset", errors_before);

        errors_before = error_count;
        axil_read(reg_info_mem_size, value);
        compare_reg("info_mem_size", value, 32'd2048);
        axil_read(reg_info_meta_width, value);
        compare_reg("info_meta_width", value, 32'd32);
        finish_test("info", errors_before);

        errors_before = error_count;
        axil_write(reg_command, reg_data_t'(cmd_nop));
        axil_read(reg_status, value);
        compare_reg("status", value, 32'h1);
        axil_read(reg_pkt_len, value);
        compare_reg("pkt_len", value, 32'h0);
        axil_read(reg_pkt_meta, value);
        compare_reg("pkt_meta", value, 32'h0);
        finish_test("nop", errors_before);

        // Idle writer drops the first packet
        errors_before = error_count;
        make_packet(int'($urandom_range(256, 64)), bytes);
        send_packet(bytes, $urandom(), 1'b1);
        axil_read(reg_pkt_len, value);
        compare_reg("pkt_len", value, 32'h0);
        axil_write(reg_command, reg_data_t'(cmd_capture));
        make_packet(int'($urandom_range(256, 64)), bytes);
        meta = $urandom();
        send_packet(bytes, meta, 1'b1);
        check_capture(bytes, meta);
        // Nop keeps the captured length and metadata
        axil_write(reg_command, reg_data_t'(cmd_nop));
        axil_read(reg_pkt_len, value);
        compare_reg("pkt_len", value, reg_data_t'(bytes.size()));
        axil_read(reg_pkt_meta, value);
        compare_reg("pkt_meta", value, reg_data_t'(meta));
        finish_test("single packet", errors_before);

        errors_before = error_count;
        for (int i = 0; i < 20; i++)
        begin
            axil_write(reg_command, reg_data_t'(cmd_capture));
            make_packet(int'($urandom_range(1500, 1)), bytes);
            meta = $urandom();
            send_packet(bytes, meta, 1'b1);
            check_capture(bytes, meta);
        end
        finish_test("packet stream", errors_before);

        errors_before = error_count;
        axil_write(reg_command, reg_data_t'(cmd_capture));
        first_len = int'($urandom_range(64, 8));
        make_packet(first_len, bytes);
        meta = $urandom();
        send_packet(bytes, meta, 1'b1);
        check_capture(bytes, meta);
        make_packet(int'($urandom_range(200, 16)), bytes);
        meta = $urandom();
        fork
            send_packet(bytes, meta, 1'b0);
            begin
                repeat (3) @(negedge clk);
                for (int i = 0; i < 10; i++)
                begin
                    @(negedge clk);
                    compare_ready("pkt_ready", pkt_ready, 1'b0);
                end
                axil_read(reg_pkt_len, value);
                compare_reg("pkt_len", value, reg_data_t'(first_len));
                axil_write(reg_command, reg_data_t'(cmd_capture));
            end
        join
        check_capture(bytes, meta);
        finish_test("back-pressure", errors_before);

        $display("tests: %0d ok, %0d with errors; checks: %0d, errors: %0d",
                 test_pass, test_fail, check_count, error_count);
        if (error_count == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

    // ==============================
    // Watchdog
    // ==============================
    initial
    begin
        #(timeout_ns);
        $display("timeout: run did not finish within %0d ns", timeout_ns);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic arst_n
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(period_ns / 2);
            clk = ~clk;
        end
    end

    // Reset released on a rising edge
    initial
    begin
        arst_n <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

// File: hdl/axil_reg_slave.sv
`timescale 1ns/1ps

module axil_reg_slave (
    input  logic                   clk,
    input  logic                   arst_n,
    input  capture_pkg::axil_req_t axil_req,
    output capture_pkg::axil_rsp_t axil_rsp,
    output capture_pkg::reg_req_t  reg_req,
    input  logic                   reg_ack,
    input  capture_pkg::reg_data_t reg_rdata
);

    import capture_pkg::*;

    typedef enum logic [1:0] {
        sl_idle,
        sl_wait,
        sl_resp
    } slave_state_t;

    slave_state_t state_q;
    logic         is_wr_q;
    logic         wr_q;
    logic         rd_q;
    logic         bvalid_q;
    logic         rvalid_q;
    reg_addr_t    addr_q;
    reg_data_t    wdata_q;
    reg_data_t    rdata_q;
    reg_data_t    wdata_masked;
    logic         wr_start;
    logic         rd_start;

    // Write needs both address and data; it beats a read in the same cycle
    assign wr_start = (state_q == sl_idle) && axil_req.awvalid && axil_req.wvalid;
    assign rd_start = (state_q == sl_idle) && axil_req.arvalid && !wr_start;

    // Disabled byte lanes read as zero downstream
    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            wdata_masked[8*i +: 8] = axil_req.wstrb[i] ? axil_req.wdata[8*i +: 8] : 8'h00;
        end
    end

    // ==============================
    // Transaction FSM
    // ==============================
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state_q  <= sl_idle;
            is_wr_q  <= 1'b0;
            wr_q     <= 1'b0;
            rd_q     <= 1'b0;
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end
        else
        begin
            // Requests last a single cycle
            wr_q <= 1'b0;
            rd_q <= 1'b0;
            case (state_q)
                sl_idle:
                begin
                    if (wr_start)
                    begin
                        wr_q    <= 1'b1;
                        is_wr_q <= 1'b1;
                        state_q <= sl_wait;
                    end
                    else if (rd_start)
                    begin
                        rd_q    <= 1'b1;
                        is_wr_q <= 1'b0;
                        state_q <= sl_wait;
                    end
                end
                sl_wait:
                begin
                    if (reg_ack)
                    begin
                        bvalid_q <= is_wr_q;
                        rvalid_q <= !is_wr_q;
                        state_q  <= sl_resp;
                    end
                end
                sl_resp:
                begin
                    // Held until the master takes it
                    if ((bvalid_q && axil_req.bready) || (rvalid_q && axil_req.rready))
                    begin
                        bvalid_q <= 1'b0;
                        rvalid_q <= 1'b0;
                        state_q  <= sl_idle;
                    end
                end
                default:
                begin
                    state_q <= sl_idle;
                end
            endcase
        end
    end

    // Address, data and read result
    always_ff @(posedge clk)
    begin
        if (wr_start)
        begin
            addr_q  <= axil_req.awaddr;
            wdata_q <= wdata_masked;
        end
        else if (rd_start)
        begin
            addr_q  <= axil_req.araddr;
            wdata_q <= '0;
        end
        if ((state_q == sl_wait) && reg_ack && !is_wr_q)
        begin
            rdata_q <= reg_rdata;
        end
    end

    assign reg_req = '{addr: addr_q, wdata: wdata_q, wr: wr_q, rd: rd_q};

    assign axil_rsp = '{
        awready: wr_start,
        wready:  wr_start,
        bvalid:  bvalid_q,
        bresp:   axil_resp_okay,
        arready: rd_start,
        rvalid:  rvalid_q,
        rdata:   rdata_q,
        rresp:   axil_resp_okay
    };

endmodule

// File: hdl/capture_pkg.sv
package capture_pkg;

    // ==============================
    // Sizes
    // ==============================
    localparam int data_bytes     = 8;
    localparam int mem_bytes      = 2048;
    localparam int mem_depth      = mem_bytes / data_bytes;
    localparam int meta_width     = 32;
    localparam int reg_addr_width = 13;

    typedef logic [data_bytes*8-1:0]         beat_data_t;
    typedef logic [$clog2(data_bytes)-1:0]   mty_t;
    typedef logic [meta_width-1:0]           meta_t;
    typedef logic [$clog2(mem_depth)-1:0]    mem_addr_t;
    typedef logic [15:0]                     pkt_len_t;
    typedef logic [reg_addr_width-1:0]       reg_addr_t;
    typedef logic [31:0]                     reg_data_t;

    // ==============================
    // Register map
    // ==============================
    localparam reg_addr_t reg_info_mem_size   = 13'h0000;
    localparam reg_addr_t reg_info_meta_width = 13'h0004;
    localparam reg_addr_t reg_command         = 13'h0008;
    localparam reg_addr_t reg_status          = 13'h000C;
    localparam reg_addr_t reg_pkt_len         = 13'h0010;
    localparam reg_addr_t reg_pkt_meta        = 13'h0014;
    // Window covers 0x1000 to 0x17FF
    localparam reg_addr_t mem_window_base     = 13'h1000;

    localparam logic [1:0] axil_resp_okay = 2'b00;

    // ==============================
    // Bundles
    // ==============================
    // First packet byte sits in data[63:56]
    typedef struct packed {
        beat_data_t data;
        mty_t       mty;
        logic       eop;
        meta_t      meta;
    } packet_beat_t;

    typedef struct packed {
        reg_addr_t  awaddr;
        logic       awvalid;
        reg_data_t  wdata;
        logic [3:0] wstrb;
        logic       wvalid;
        logic       bready;
        reg_addr_t  araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
        logic       arready;
        logic       rvalid;
        reg_data_t  rdata;
        logic [1:0] rresp;
    } axil_rsp_t;

    typedef struct packed {
        reg_addr_t addr;
        reg_data_t wdata;
        logic      wr;
        logic      rd;
    } reg_req_t;

    typedef enum logic [7:0] {
        cmd_nop     = 8'd0,
        cmd_capture = 8'd1
    } capture_cmd_t;

    typedef struct packed {
        logic     done;
        logic     error;
        pkt_len_t len;
        meta_t    meta;
    } capture_status_t;

    typedef enum logic [1:0] {
        idle,
        armed,
        capturing,
        held
    } capture_state_t;

endpackage

// File: hdl/capture_regs.sv
`timescale 1ns/1ps

module capture_regs (
    input  logic                         clk,
    input  logic                         arst_n,
    input  capture_pkg::reg_req_t        reg_req,
    output logic                         reg_ack,
    output capture_pkg::reg_data_t       reg_rdata,
    output logic                         cmd_valid,
    output capture_pkg::capture_cmd_t    cmd,
    input  capture_pkg::capture_status_t status,
    output capture_pkg::mem_addr_t       mem_raddr,
    input  capture_pkg::beat_data_t      mem_rdata
);

    import capture_pkg::*;

    logic         win_hit;
    logic         win_pend_q;
    logic         win_lo_q;
    logic         cmd_known;
    capture_cmd_t cmd_next;
    reg_data_t    rd_value;

    // ==============================
    // Decode
    // ==============================
    assign win_hit   = (reg_req.addr & ~reg_addr_t'(mem_bytes - 1)) == mem_window_base;
    assign mem_raddr = mem_addr_t'(reg_req.addr >> $clog2(data_bytes));

    always_comb
    begin
        case (reg_req.addr)
            reg_info_mem_size:   rd_value = reg_data_t'(mem_bytes);
            reg_info_meta_width: rd_value = reg_data_t'(meta_width);
            reg_status:          rd_value = reg_data_t'({status.error, status.done});
            reg_pkt_len:         rd_value = reg_data_t'(status.len);
            reg_pkt_meta:        rd_value = reg_data_t'(status.meta);
            default:             rd_value = '0;
        endcase
    end

    // Unknown command codes are dropped
    always_comb
    begin
        case (reg_req.wdata)
            reg_data_t'(cmd_capture):
            begin
                cmd_next  = cmd_capture;
                cmd_known = 1'b1;
            end
            reg_data_t'(cmd_nop):
            begin
                cmd_next  = cmd_nop;
                cmd_known = 1'b1;
            end
            default:
            begin
                cmd_next  = cmd_nop;
                cmd_known = 1'b0;
            end
        endcase
    end

    // ==============================
    // Ack and command pulse
    // ==============================
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            reg_ack    <= 1'b0;
            cmd_valid  <= 1'b0;
            win_pend_q <= 1'b0;
        end
        else
        begin
            reg_ack    <= 1'b0;
            cmd_valid  <= 1'b0;
            win_pend_q <= 1'b0;
            if (win_pend_q)
            begin
                reg_ack <= 1'b1;
            end
            else if (reg_req.rd && win_hit)
            begin
                // Memory read is registered, one extra cycle
                win_pend_q <= 1'b1;
            end
            else if (reg_req.rd || reg_req.wr)
            begin
                reg_ack <= 1'b1;
            end
            if (reg_req.wr && (reg_req.addr == reg_command) && cmd_known)
            begin
                cmd_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (win_pend_q)
        begin
            // Byte A lives in the upper half when A[2] is clear
            reg_rdata <= win_lo_q ? mem_rdata[31:0] : mem_rdata[63:32];
        end
        else if (reg_req.rd)
        begin
            reg_rdata <= rd_value;
        end
        if (reg_req.rd)
        begin
            win_lo_q <= reg_req.addr[2];
        end
        if (reg_req.wr)
        begin
            cmd <= cmd_next;
        end
    end

endmodule

// File: hdl/capture_writer.sv
`timescale 1ns/1ps

module capture_writer (
    input  logic                         clk,
    input  logic                         arst_n,
    input  capture_pkg::packet_beat_t    pkt,
    input  logic                         pkt_valid,
    output logic                         pkt_ready,
    input  logic                         cmd_valid,
    input  capture_pkg::capture_cmd_t    cmd,
    output capture_pkg::capture_status_t status,
    output logic                         mem_we,
    output capture_pkg::mem_addr_t       mem_waddr,
    output capture_pkg::beat_data_t      mem_wdata
);

    import capture_pkg::*;

    capture_state_t state_q;
    logic           in_pkt_q;
    logic           full_q;
    logic           done_q;
    logic           error_q;
    mem_addr_t      waddr_q;
    pkt_len_t       byte_cnt_q;
    pkt_len_t       len_q;
    meta_t          meta_q;
    pkt_len_t       beat_bytes;
    pkt_len_t       byte_sum;
    logic           accept;
    logic           take;

    // Stall only while a finished capture waits for software
    assign pkt_ready = (state_q != held);
    assign accept    = pkt_valid && pkt_ready;

    // Armed writer starts on a packet boundary only
    assign take = accept && (((state_q == armed) && !in_pkt_q) || (state_q == capturing));

    assign beat_bytes = pkt.eop ? pkt_len_t'(data_bytes) - pkt_len_t'(pkt.mty)
                                : pkt_len_t'(data_bytes);
    assign byte_sum   = byte_cnt_q + beat_bytes;

    assign mem_we    = take && !full_q;
    assign mem_waddr = waddr_q;
    assign mem_wdata = pkt.data;

    // ==============================
    // Capture FSM
    // ==============================
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state_q    <= idle;
            in_pkt_q   <= 1'b0;
            full_q     <= 1'b0;
            done_q     <= 1'b0;
            error_q    <= 1'b0;
            waddr_q    <= '0;
            byte_cnt_q <= '0;
            len_q      <= '0;
            meta_q     <= '0;
        end
        else
        begin
            if (accept)
            begin
                in_pkt_q <= !pkt.eop;
            end
            if (cmd_valid)
            begin
                done_q  <= (cmd != cmd_capture);
                error_q <= 1'b0;
                if (cmd == cmd_capture)
                begin
                    state_q    <= armed;
                    waddr_q    <= '0;
                    full_q     <= 1'b0;
                    byte_cnt_q <= '0;
                end
                else
                begin
                    state_q <= idle;
                end
            end
            else if (take)
            begin
                byte_cnt_q <= byte_sum;
                state_q    <= capturing;
                // Truncate past the end of memory but keep counting
                if (full_q)
                begin
                    error_q <= 1'b1;
                end
                else
                begin
                    waddr_q <= waddr_q + 1'b1;
                    if (waddr_q == mem_addr_t'(mem_depth - 1))
                    begin
                        full_q <= 1'b1;
                    end
                end
                if (pkt.eop)
                begin
                    len_q   <= byte_sum;
                    meta_q  <= pkt.meta;
                    done_q  <= 1'b1;
                    state_q <= held;
                end
            end
        end
    end

    assign status = '{done: done_q, error: error_q, len: len_q, meta: meta_q};

endmodule

// File: hdl/packet_capture.sv
`timescale 1ns/1ps

module packet_capture (
    input  logic                      clk,
    input  logic                      arst_n,
    input  capture_pkg::axil_req_t    axil_req,
    output capture_pkg::axil_rsp_t    axil_rsp,
    input  capture_pkg::packet_beat_t pkt,
    input  logic                      pkt_valid,
    output logic                      pkt_ready
);

    import capture_pkg::*;

    reg_req_t        reg_req;
    logic            reg_ack;
    reg_data_t       reg_rdata;
    logic            cmd_valid;
    capture_cmd_t    cmd;
    capture_status_t status;
    logic            mem_we;
    mem_addr_t       mem_waddr;
    beat_data_t      mem_wdata;
    mem_addr_t       mem_raddr;
    beat_data_t      mem_rdata;

    // ==============================
    // Register side
    // ==============================
    axil_reg_slave u_axil_reg_slave (
        .clk       (clk),
        .arst_n    (arst_n),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .reg_req   (reg_req),
        .reg_ack   (reg_ack),
        .reg_rdata (reg_rdata)
    );

    capture_regs u_capture_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .reg_req   (reg_req),
        .reg_ack   (reg_ack),
        .reg_rdata (reg_rdata),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .status    (status),
        .mem_raddr (mem_raddr),
        .mem_rdata (mem_rdata)
    );

    // ==============================
    // Packet side
    // ==============================
    capture_writer u_capture_writer (
        .clk       (clk),
        .arst_n    (arst_n),
        .pkt       (pkt),
        .pkt_valid (pkt_valid),
        .pkt_ready (pkt_ready),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .status    (status),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata)
    );

    packet_mem u_packet_mem (
        .clk   (clk),
        .we    (mem_we),
        .waddr (mem_waddr),
        .wdata (mem_wdata),
        .raddr (mem_raddr),
        .rdata (mem_rdata)
    );

endmodule

// File: hdl/packet_mem.sv
`timescale 1ns/1ps

module packet_mem (
    input  logic                    clk,
    input  logic                    we,
    input  capture_pkg::mem_addr_t  waddr,
    input  capture_pkg::beat_data_t wdata,
    input  capture_pkg::mem_addr_t  raddr,
    output capture_pkg::beat_data_t rdata
);

    import capture_pkg::*;

    // One packet worth of beats
    beat_data_t mem [mem_depth];

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
    end

    // Read data lands one cycle after the address
    always_ff @(posedge clk)
    begin
        rdata <= mem[raddr];
    end

endmodule

// File: list.f
hdl/capture_pkg.sv
hdl/axil_reg_slave.sv
hdl/capture_regs.sv
hdl/capture_writer.sv
hdl/packet_mem.sv
hdl/packet_capture.sv
bench/tb_clock.sv
bench/packet_capture_tb.sv
